/* Bender.yml */
package:
  name: bus_ctrl

export_include_dirs:
  - include

sources:
  - logic/bus_ctrl_pkg.sv
  - logic/bus_ctrl_cfg.sv
  - logic/controller_active.sv
  - logic/controller_standby.sv
  - logic/controller.sv
  - target: simulation
    files:
      - sim/tb_controller.sv

/* include/bus_ctrl_settings.svh */
/*
 * Bus controller settings
 * Field widths, configuration register map and register reset values
 */
`ifndef BUS_CTRL_SETTINGS_SVH
`define BUS_CTRL_SETTINGS_SVH

// Bus address and SCL timing widths
`define BUS_CTRL_ADDR_W 7
`define BUS_CTRL_HALF_W 16
`define BUS_CTRL_CFG_AW 2

// Configuration register map
`define BUS_CTRL_REG_ROLE     2'd0
`define BUS_CTRL_REG_HALF     2'd1
`define BUS_CTRL_REG_OWN_ADDR 2'd2

// Register reset values
`define BUS_CTRL_HALF_RST     16'd4
`define BUS_CTRL_OWN_ADDR_RST 7'h2a

`endif

/* logic/bus_ctrl_cfg.sv */
/*
 * Bus controller configuration registers
 * Role select, SCL half-period and standby own address, written by strobe
 */
`default_nettype none
`include "bus_ctrl_settings.svh"

module bus_ctrl_cfg
    import bus_ctrl_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    input  logic      cfg_we_i,
    input  cfg_addr_t cfg_addr_i,
    input  half_cnt_t cfg_wdata_i,

    output bus_cfg_t  cfg_o
);

    bus_cfg_t cfg_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cfg_q.standby_sel <= 1'b0;
            cfg_q.half        <= `BUS_CTRL_HALF_RST;
            cfg_q.own_addr    <= `BUS_CTRL_OWN_ADDR_RST;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                `BUS_CTRL_REG_ROLE:     cfg_q.standby_sel <= cfg_wdata_i[0];
                // Zero would freeze the SCL generator
                `BUS_CTRL_REG_HALF:     cfg_q.half <= (cfg_wdata_i == '0) ? half_cnt_t'(1)
                                                                          : cfg_wdata_i;
                `BUS_CTRL_REG_OWN_ADDR: cfg_q.own_addr <= cfg_wdata_i[`BUS_CTRL_ADDR_W-1:0];
                default: ;
            endcase
        end
    end

    assign cfg_o = cfg_q;

endmodule

`default_nettype wire

/* logic/bus_ctrl_pkg.sv */
/*
 * Bus controller package
 * Shared vector types, command/response/config structs and FSM encodings
 */
`default_nettype none
`include "bus_ctrl_settings.svh"

package bus_ctrl_pkg;

    typedef logic [`BUS_CTRL_ADDR_W-1:0] bus_addr_t;
    typedef logic [7:0]                  bus_byte_t;
    typedef logic [`BUS_CTRL_HALF_W-1:0] half_cnt_t;
    typedef logic [`BUS_CTRL_CFG_AW-1:0] cfg_addr_t;

    // One write transaction
    typedef struct packed {
        bus_addr_t addr;
        bus_byte_t data;
    } bus_cmd_t;

    // Set when the target pulled SDA low in that ACK slot
    typedef struct packed {
        logic addr_ack;
        logic data_ack;
    } bus_resp_t;

    typedef struct packed {
        logic      standby_sel;
        half_cnt_t half;
        bus_addr_t own_addr;
    } bus_cfg_t;

    typedef enum logic [2:0] {
        ACT_IDLE,
        ACT_START,
        ACT_BIT,
        ACT_ACK,
        ACT_STOP,
        ACT_DONE
    } active_state_e;

    typedef enum logic [2:0] {
        SBY_IDLE,
        SBY_ADDR,
        SBY_ADDR_ACK,
        SBY_DATA,
        SBY_DATA_ACK,
        SBY_WAIT_STOP
    } standby_state_e;

endpackage

`default_nettype wire

/* logic/controller.sv */
/*
 * Serial bus controller top
 * Config registers, active and standby controllers, PHY pin mux
 */
`default_nettype none

module controller
    import bus_ctrl_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // Configuration writes
    input  logic      cfg_we_i,
    input  cfg_addr_t cfg_addr_i,
    input  half_cnt_t cfg_wdata_i,

    // Active controller commands and responses
    input  logic      cmd_valid_i,
    input  bus_cmd_t  cmd_i,
    output logic      busy_o,
    output logic      resp_valid_o,
    output bus_resp_t resp_o,

    // PHY pins
    input  logic      scl_i,
    input  logic      sda_i,
    output logic      scl_o,
    output logic      sda_o,

    // Standby bus events
    output logic      bus_start_o,
    output logic      bus_stop_o,
    output bus_byte_t bus_addr_o,
    output logic      bus_addr_valid_o,
    output logic      rx_valid_o,
    output bus_byte_t rx_data_o
);

    bus_cfg_t cfg;
    logic     act_scl_o;
    logic     act_sda_o;
    logic     act_scl_i;
    logic     act_sda_i;
    logic     sby_sda_o;
    logic     sby_scl_i;
    logic     sby_sda_i;

    // 2:1 pin mux, the unselected controller sees a quiet bus
    always_comb begin : mux_2_to_1
        if (cfg.standby_sel) begin
            scl_o     = 1'b1;
            sda_o     = sby_sda_o;
            sby_scl_i = scl_i;
            sby_sda_i = sda_i;
            act_scl_i = act_scl_o;
            act_sda_i = 1'b1;
        end else begin
            scl_o     = act_scl_o;
            sda_o     = act_sda_o;
            act_scl_i = scl_i;
            act_sda_i = sda_i;
            sby_scl_i = 1'b1;
            sby_sda_i = 1'b1;
        end
    end

    bus_ctrl_cfg xbus_ctrl_cfg (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cfg_we_i   (cfg_we_i),
        .cfg_addr_i (cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i),
        .cfg_o      (cfg)
    );

    controller_active xcontroller_active (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .half_i      (cfg.half),
        .scl_i       (act_scl_i),
        .sda_i       (act_sda_i),
        .scl_o       (act_scl_o),
        .sda_o       (act_sda_o),
        .busy_o      (busy_o),
        .resp_valid_o(resp_valid_o),
        .resp_o      (resp_o)
    );

    controller_standby xcontroller_standby (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .own_addr_i      (cfg.own_addr),
        .scl_i           (sby_scl_i),
        .sda_i           (sby_sda_i),
        .sda_o           (sby_sda_o),
        .bus_start_o     (bus_start_o),
        .bus_stop_o      (bus_stop_o),
        .bus_addr_o      (bus_addr_o),
        .bus_addr_valid_o(bus_addr_valid_o),
        .rx_valid_o      (rx_valid_o),
        .rx_data_o       (rx_data_o)
    );

endmodule

`default_nettype wire

/* logic/controller_active.sv */
/*
 * Active bus controller
 * Drives SCL/SDA for a single write: start, address byte with write bit,
 * one data byte, an ACK slot after each byte and a stop
 */
`default_nettype none

module controller_active
    import bus_ctrl_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    input  logic      cmd_valid_i,
    input  bus_cmd_t  cmd_i,
    input  half_cnt_t half_i,

    input  logic      scl_i,
    input  logic      sda_i,
    output logic      scl_o,
    output logic      sda_o,

    output logic      busy_o,
    output logic      resp_valid_o,
    output bus_resp_t resp_o
);

    active_state_e state_q;
    half_cnt_t     cnt_q;
    logic [2:0]    bit_q;
    logic          byte_sel_q;
    logic          scl_q;
    logic          sda_q;
    logic          busy_q;
    logic          resp_valid_q;
    bus_resp_t     resp_q;
    bus_cmd_t      cmd_q;
    bus_byte_t     cur_byte;
    logic          accept;
    logic          cnt_run;
    logic          half_done;

    assign accept   = cmd_valid_i && (state_q == ACT_IDLE);
    assign cur_byte = byte_sel_q ? cmd_q.data : {cmd_q.addr, 1'b0};

    // High half starts counting only once the line is seen high
    assign cnt_run   = !scl_q || scl_i;
    assign half_done = cnt_run && (cnt_q >= half_i - half_cnt_t'(1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= ACT_IDLE;
            cnt_q        <= '0;
            bit_q        <= '0;
            byte_sel_q   <= 1'b0;
            scl_q        <= 1'b1;
            sda_q        <= 1'b1;
            busy_q       <= 1'b0;
            resp_valid_q <= 1'b0;
            resp_q       <= '0;
        end else begin
            resp_valid_q <= 1'b0;
            if (state_q != ACT_IDLE && cnt_run) begin
                cnt_q <= half_done ? '0 : cnt_q + half_cnt_t'(1);
            end
            case (state_q)
                ACT_IDLE: begin
                    if (accept) begin
                        // Start condition, SDA falls with SCL high
                        sda_q      <= 1'b0;
                        busy_q     <= 1'b1;
                        byte_sel_q <= 1'b0;
                        resp_q     <= '0;
                        state_q    <= ACT_START;
                    end
                end
                ACT_START: begin
                    if (half_done) begin
                        scl_q   <= 1'b0;
                        sda_q   <= cur_byte[7];
                        bit_q   <= 3'd7;
                        state_q <= ACT_BIT;
                    end
                end
                ACT_BIT: begin
                    if (half_done) begin
                        scl_q <= !scl_q;
                        if (scl_q && bit_q == 3'd0) begin
                            sda_q   <= 1'b1;
                            state_q <= ACT_ACK;
                        end else if (scl_q) begin
                            sda_q <= cur_byte[bit_q - 3'd1];
                            bit_q <= bit_q - 3'd1;
                        end
                    end
                end
                ACT_ACK: begin
                    if (half_done) begin
                        scl_q <= !scl_q;
                        if (scl_q && !byte_sel_q) begin
                            resp_q.addr_ack <= !sda_i;
                            byte_sel_q      <= 1'b1;
                            bit_q           <= 3'd7;
                            sda_q           <= cmd_q.data[7];
                            state_q         <= ACT_BIT;
                        end else if (scl_q) begin
                            resp_q.data_ack <= !sda_i;
                            sda_q           <= 1'b0;
                            state_q         <= ACT_STOP;
                        end
                    end
                end
                ACT_STOP: begin
                    if (half_done && !scl_q) begin
                        scl_q <= 1'b1;
                    end else if (half_done) begin
                        sda_q   <= 1'b1;
                        state_q <= ACT_DONE;
                    end
                end
                ACT_DONE: begin
                    // Bus free for one half before reporting
                    if (half_done) begin
                        busy_q       <= 1'b0;
                        resp_valid_q <= 1'b1;
                        state_q      <= ACT_IDLE;
                    end
                end
                default: state_q <= ACT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            cmd_q <= cmd_i;
        end
    end

    assign scl_o        = scl_q;
    assign sda_o        = sda_q;
    assign busy_o       = busy_q;
    assign resp_valid_o = resp_valid_q;
    assign resp_o       = resp_q;

endmodule

`default_nettype wire

/* logic/controller_standby.sv */
/*
 * Standby bus controller
 * Monitors SCL/SDA for start and stop, receives the address byte and,
 * on an own-address write, ACKs and receives one data byte
 */
`default_nettype none

module controller_standby
    import bus_ctrl_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    input  bus_addr_t own_addr_i,

    input  logic      scl_i,
    input  logic      sda_i,
    output logic      sda_o,

    output logic      bus_start_o,
    output logic      bus_stop_o,
    output bus_byte_t bus_addr_o,
    output logic      bus_addr_valid_o,
    output logic      rx_valid_o,
    output bus_byte_t rx_data_o
);

    logic [1:0]     scl_sync_q;
    logic [1:0]     sda_sync_q;
    logic           scl_d_q;
    logic           sda_d_q;
    logic           scl_s;
    logic           sda_s;
    logic           scl_rise;
    logic           scl_fall;
    logic           start_det;
    logic           stop_det;
    standby_state_e state_q;
    logic [2:0]     bit_cnt_q;
    logic           sda_q;
    logic           start_q;
    logic           stop_q;
    logic           addr_valid_q;
    logic           rx_valid_q;
    bus_byte_t      shift_q;
    bus_byte_t      addr_q;
    bus_byte_t      rx_data_q;
    bus_byte_t      byte_in;
    logic           shift_en;
    logic           addr_done;
    logic           data_done;
    logic           addr_match;

    // Two-flop synchronizer plus one delayed copy for edge detection
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            scl_sync_q <= 2'b11;
            sda_sync_q <= 2'b11;
            scl_d_q    <= 1'b1;
            sda_d_q    <= 1'b1;
        end else begin
            scl_sync_q <= {scl_sync_q[0], scl_i};
            sda_sync_q <= {sda_sync_q[0], sda_i};
            scl_d_q    <= scl_s;
            sda_d_q    <= sda_s;
        end
    end

    assign scl_s     = scl_sync_q[1];
    assign sda_s     = sda_sync_q[1];
    assign scl_rise  = scl_s && !scl_d_q;
    assign scl_fall  = !scl_s && scl_d_q;
    assign start_det = scl_s && scl_d_q && sda_d_q && !sda_s;
    assign stop_det  = scl_s && scl_d_q && !sda_d_q && sda_s;

    assign byte_in    = {shift_q[6:0], sda_s};
    assign shift_en   = scl_rise && (state_q == SBY_ADDR || state_q == SBY_DATA);
    assign addr_done  = shift_en && (state_q == SBY_ADDR) && (bit_cnt_q == 3'd7);
    assign data_done  = shift_en && (state_q == SBY_DATA) && (bit_cnt_q == 3'd7);
    assign addr_match = (addr_q[7:1] == own_addr_i) && !addr_q[0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= SBY_IDLE;
            bit_cnt_q    <= '0;
            sda_q        <= 1'b1;
            start_q      <= 1'b0;
            stop_q       <= 1'b0;
            addr_valid_q <= 1'b0;
            rx_valid_q   <= 1'b0;
        end else begin
            start_q      <= start_det;
            stop_q       <= stop_det;
            addr_valid_q <= addr_done;
            rx_valid_q   <= data_done;
            if (shift_en) begin
                bit_cnt_q <= bit_cnt_q + 3'd1;
            end
            if (start_det) begin
                sda_q     <= 1'b1;
                bit_cnt_q <= '0;
                state_q   <= SBY_ADDR;
            end else if (stop_det) begin
                sda_q   <= 1'b1;
                state_q <= SBY_IDLE;
            end else begin
                case (state_q)
                    SBY_ADDR:     if (addr_done) state_q <= SBY_ADDR_ACK;
                    SBY_DATA:     if (data_done) state_q <= SBY_DATA_ACK;
                    // First fall opens the ACK slot, second one closes it
                    SBY_ADDR_ACK: begin
                        if (scl_fall && !sda_q) begin
                            sda_q     <= 1'b1;
                            bit_cnt_q <= '0;
                            state_q   <= SBY_DATA;
                        end else if (scl_fall && addr_match) begin
                            sda_q <= 1'b0;
                        end else if (scl_fall) begin
                            state_q <= SBY_WAIT_STOP;
                        end
                    end
                    SBY_DATA_ACK: begin
                        if (scl_fall && !sda_q) begin
                            sda_q   <= 1'b1;
                            state_q <= SBY_WAIT_STOP;
                        end else if (scl_fall) begin
                            sda_q <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (shift_en) begin
            shift_q <= byte_in;
        end
        if (addr_done) begin
            addr_q <= byte_in;
        end
        if (data_done) begin
            rx_data_q <= byte_in;
        end
    end

    assign sda_o            = sda_q;
    assign bus_start_o      = start_q;
    assign bus_stop_o       = stop_q;
    assign bus_addr_o       = addr_q;
    assign bus_addr_valid_o = addr_valid_q;
    assign rx_valid_o       = rx_valid_q;
    assign rx_data_o        = rx_data_q;

endmodule

`default_nettype wire

/* project.f */
+incdir+include
logic/bus_ctrl_pkg.sv
logic/bus_ctrl_cfg.sv
logic/controller_active.sv
logic/controller_standby.sv
logic/controller.sv
sim/tb_controller.sv

/* sim/tb_controller.sv */
/*
 * Testbench for the serial bus controller
 * Target and master bus models, directed tests of both controller roles
 */
`default_nettype none
`include "bus_ctrl_settings.svh"

module tb_controller
    import bus_ctrl_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int        TIMEOUT     = 2000;
    localparam int        MASTER_HALF = 8;
    localparam bus_addr_t MODEL_ADDR  = 7'h51;
    localparam int        EV_START    = 1;
    localparam int        EV_ADDR     = 2;
    localparam int        EV_ACK      = 3;
    localparam int        EV_RX       = 4;
    localparam int        EV_STOP     = 5;

    logic      clk_i;
    logic      rst_i;
    logic      cfg_we_i;
    cfg_addr_t cfg_addr_i;
    half_cnt_t cfg_wdata_i;
    logic      cmd_valid_i;
    bus_cmd_t  cmd_i;
    logic      busy_o;
    logic      resp_valid_o;
    bus_resp_t resp_o;
    logic      scl_i;
    logic      sda_i;
    logic      scl_o;
    logic      sda_o;
    logic      bus_start_o;
    logic      bus_stop_o;
    bus_byte_t bus_addr_o;
    logic      bus_addr_valid_o;
    logic      rx_valid_o;
    bus_byte_t rx_data_o;

    // Bus model side of the wired AND
    logic        tb_scl;
    logic        tb_sda;
    logic [31:0] lcg_state;
    int          events[$];
    bus_byte_t   seen_addr;
    bus_byte_t   seen_data;

    assign scl_i = scl_o & tb_scl;
    assign sda_i = sda_o & tb_sda;

    controller u_controller (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .cfg_we_i        (cfg_we_i),
        .cfg_addr_i      (cfg_addr_i),
        .cfg_wdata_i     (cfg_wdata_i),
        .cmd_valid_i     (cmd_valid_i),
        .cmd_i           (cmd_i),
        .busy_o          (busy_o),
        .resp_valid_o    (resp_valid_o),
        .resp_o          (resp_o),
        .scl_i           (scl_i),
        .sda_i           (sda_i),
        .scl_o           (scl_o),
        .sda_o           (sda_o),
        .bus_start_o     (bus_start_o),
        .bus_stop_o      (bus_stop_o),
        .bus_addr_o      (bus_addr_o),
        .bus_addr_valid_o(bus_addr_valid_o),
        .rx_valid_o      (rx_valid_o),
        .rx_data_o       (rx_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s, got %b, expected %b",
                                     $time, msg, got, exp));
        end
    endtask

    task automatic check_byte(input bus_byte_t got, input bus_byte_t exp, input string msg);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s, got %h, expected %h",
                                     $time, msg, got, exp));
        end
    endtask

    task automatic check_resp(input bus_resp_t got, input bus_resp_t exp, input string msg);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s, got %b, expected %b",
                                     $time, msg, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string msg);
        if (got != exp) begin
            report_failure($sformatf("Mismatch at %0t: %s, got %0d, expected %0d",
                                     $time, msg, got, exp));
        end
    endtask

    task automatic check_events(input int exp[$], input string msg);
        check_count(events.size(), exp.size(), {msg, " event count"});
        foreach (exp[i]) begin
            check_count(events[i], exp[i], $sformatf("%s event %0d", msg, i));
        end
    endtask

    task automatic write_cfg(input cfg_addr_t addr, input half_cnt_t data);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(negedge clk_i);
        cfg_we_i = 1'b0;
    endtask

    task automatic wait_scl(input logic level);
        int n;
        n = 0;
        while (scl_i !== level) begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT) begin
                report_failure($sformatf("Timeout: SCL never went to %b", level));
            end
        end
    endtask

    task automatic wait_start_cond();
        int n;
        n = 0;
        while (!(scl_i === 1'b1 && sda_i === 1'b0)) begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT) begin
                report_failure("Timeout: no start condition appeared on the bus");
            end
        end
    endtask

    // Target side: collects both bytes, ACKs when the address is its own
    task automatic target_model(input bus_addr_t model_addr,
                                output bus_byte_t addr_byte, output bus_byte_t data_byte);
        bus_byte_t shift;
        logic      ack;
        ack   = 1'b0;
        shift = '0;
        wait_start_cond();
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < 8; i++) begin
                wait_scl(1'b0);
                wait_scl(1'b1);
                shift = {shift[6:0], sda_i};
            end
            if (b == 0) begin
                addr_byte = shift;
                ack       = (shift == {model_addr, 1'b0});
            end else begin
                data_byte = shift;
            end
            wait_scl(1'b0);
            if (ack) begin
                tb_sda = 1'b0;
            end
            wait_scl(1'b1);
            wait_scl(1'b0);
            tb_sda = 1'b1;
        end
    endtask

    // Length of the first SCL low half and the high half after it
    task automatic measure_scl(output int low_len, output int high_len);
        wait_scl(1'b0);
        low_len = 0;
        while (scl_i === 1'b0) begin
            low_len++;
            @(negedge clk_i);
            if (low_len > TIMEOUT) begin
                report_failure("Timeout: SCL never came back high");
            end
        end
        high_len = 0;
        while (scl_i === 1'b1) begin
            high_len++;
            @(negedge clk_i);
            if (high_len > TIMEOUT) begin
                report_failure("Timeout: SCL never went low after the high half");
            end
        end
    endtask

    task automatic run_write(input bus_cmd_t c, input logic extra_pulse,
                             output bus_resp_t resp);
        int n;
        cmd_i       = c;
        cmd_valid_i = 1'b1;
        @(negedge clk_i);
        cmd_valid_i = 1'b0;
        check_bit(busy_o, 1'b1, "busy_o after accepted command");
        if (extra_pulse) begin
            cmd_i       = bus_cmd_t'(~c);
            cmd_valid_i = 1'b1;
            @(negedge clk_i);
            cmd_valid_i = 1'b0;
        end
        n = 0;
        while (resp_valid_o !== 1'b1) begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT) begin
                report_failure("Timeout: the active controller never sent a response");
            end
        end
        resp = resp_o;
        check_bit(busy_o, 1'b0, "busy_o with resp_valid_o");
    endtask

    task automatic active_write(input bus_cmd_t c, input bus_addr_t model_addr,
                                input int half, input logic extra_pulse);
        bus_byte_t addr_byte;
        bus_byte_t data_byte;
        bus_resp_t resp;
        bus_resp_t exp_resp;
        int        low_len;
        int        high_len;
        fork
            target_model(model_addr, addr_byte, data_byte);
            measure_scl(low_len, high_len);
            run_write(c, extra_pulse, resp);
        join
        exp_resp.addr_ack = (c.addr == model_addr);
        exp_resp.data_ack = (c.addr == model_addr);
        check_byte(addr_byte, {c.addr, 1'b0}, "address byte seen by target");
        check_byte(data_byte, c.data, "data byte seen by target");
        check_resp(resp, exp_resp, "resp_o ACK bits");
        check_count(low_len, half, "SCL low length");
        check_count(high_len, half, "SCL high length");
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            check_bit(busy_o, 1'b0, "busy_o after an ignored command");
            check_bit(resp_valid_o, 1'b0, "resp_valid_o for an ignored command");
        end
    endtask

    task automatic master_bit(input logic value);
        tb_sda = value;
        repeat (MASTER_HALF) @(negedge clk_i);
        tb_scl = 1'b1;
        repeat (MASTER_HALF) @(negedge clk_i);
        tb_scl = 1'b0;
        @(negedge clk_i);
    endtask

    // Master side: start, two bytes with ACK slots, stop
    task automatic master_send(input bus_byte_t b0, input bus_byte_t b1,
                               output logic [1:0] acks);
        bus_byte_t bytes[2];
        bytes[0] = b0;
        bytes[1] = b1;
        tb_sda   = 1'b0;
        repeat (MASTER_HALF) @(negedge clk_i);
        tb_scl = 1'b0;
        @(negedge clk_i);
        for (int b = 0; b < 2; b++) begin
            for (int i = 7; i >= 0; i--) begin
                master_bit(bytes[b][i]);
            end
            tb_sda = 1'b1;
            repeat (MASTER_HALF) @(negedge clk_i);
            tb_scl = 1'b1;
            repeat (MASTER_HALF) @(negedge clk_i);
            acks[1-b] = !sda_i;
            tb_scl    = 1'b0;
            @(negedge clk_i);
        end
        tb_sda = 1'b0;
        repeat (MASTER_HALF) @(negedge clk_i);
        tb_scl = 1'b1;
        repeat (MASTER_HALF) @(negedge clk_i);
        tb_sda = 1'b1;
        repeat (MASTER_HALF) @(negedge clk_i);
    endtask

    task automatic record_events();
        int   n;
        logic sda_prev;
        logic done;
        n        = 0;
        done     = 1'b0;
        sda_prev = sda_o;
        events.delete();
        while (!done) begin
            @(negedge clk_i);
            n++;
            if (bus_start_o) events.push_back(EV_START);
            if (bus_addr_valid_o) begin
                events.push_back(EV_ADDR);
                seen_addr = bus_addr_o;
            end
            // Standby pulling SDA marks an ACK
            if (sda_prev && !sda_o) events.push_back(EV_ACK);
            if (rx_valid_o) begin
                events.push_back(EV_RX);
                seen_data = rx_data_o;
            end
            if (bus_stop_o) begin
                events.push_back(EV_STOP);
                done = 1'b1;
            end
            sda_prev = sda_o;
            if (!done && n > TIMEOUT) begin
                report_failure("Timeout: the standby controller never reported a stop");
            end
        end
    endtask

    task automatic standby_receive(input bus_addr_t addr, input bus_byte_t data,
                                   input logic own);
        logic [1:0] acks;
        int         exp_ev[$];
        fork
            master_send({addr, 1'b0}, data, acks);
            record_events();
        join
        check_byte(seen_addr, {addr, 1'b0}, "bus_addr_o");
        check_bit(acks[1], own, "address ACK on sda_o");
        check_bit(acks[0], own, "data ACK on sda_o");
        if (own) begin
            check_byte(seen_data, data, "rx_data_o");
            exp_ev = '{EV_START, EV_ADDR, EV_ACK, EV_RX, EV_ACK, EV_STOP};
        end else begin
            exp_ev = '{EV_START, EV_ADDR, EV_STOP};
        end
        check_events(exp_ev, "standby");
    endtask

    task automatic test_reset();
        check_bit(busy_o, 1'b0, "busy_o after reset");
        check_bit(resp_valid_o, 1'b0, "resp_valid_o after reset");
        check_bit(bus_start_o, 1'b0, "bus_start_o after reset");
        check_bit(bus_stop_o, 1'b0, "bus_stop_o after reset");
        check_bit(bus_addr_valid_o, 1'b0, "bus_addr_valid_o after reset");
        check_bit(rx_valid_o, 1'b0, "rx_valid_o after reset");
        check_bit(scl_o, 1'b1, "scl_o after reset");
        check_bit(sda_o, 1'b1, "sda_o after reset");
    endtask

    initial begin
        bus_addr_t own;
        lcg_state   = 32'h10809f77;
        rst_i       = 1'b1;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = '0;
        cfg_wdata_i = '0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        tb_scl      = 1'b1;
        tb_sda      = 1'b1;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        @(negedge clk_i);

        test_reset();

        write_cfg(`BUS_CTRL_REG_ROLE, 16'd0);
        write_cfg(`BUS_CTRL_REG_HALF, 16'd4);
        active_write({MODEL_ADDR, bus_byte_t'(next_random())}, MODEL_ADDR, 4, 1'b0);

        // Absent target plus a pulse while busy
        active_write({MODEL_ADDR ^ 7'h10, bus_byte_t'(next_random())}, MODEL_ADDR, 4, 1'b1);
        check_quiet(100);

        write_cfg(`BUS_CTRL_REG_HALF, 16'd8);
        active_write({MODEL_ADDR, bus_byte_t'(next_random())}, MODEL_ADDR, 8, 1'b0);
        write_cfg(`BUS_CTRL_REG_HALF, 16'd0);
        active_write({MODEL_ADDR, bus_byte_t'(next_random())}, MODEL_ADDR, 1, 1'b0);

        write_cfg(`BUS_CTRL_REG_ROLE, 16'd1);
        own = bus_addr_t'(next_random() >> 9);
        write_cfg(`BUS_CTRL_REG_OWN_ADDR, half_cnt_t'(own));
        standby_receive(own, bus_byte_t'(next_random()), 1'b1);
        standby_receive(own ^ 7'h05, bus_byte_t'(next_random()), 1'b0);

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
